// ==== all.f ====
hw/axis_out_pkg.sv
hw/host_write_port.sv
hw/axis_out_fifo.sv
hw/axis_serializer.sv
hw/axis_out_top.sv
verif/axis_out_checker.sv
verif/axis_out_properties.sv
verif/tb_axis_out.sv

// ==== hw/axis_out_fifo.sv ====
`timescale 1ns/1ps

module axis_out_fifo (
   input  logic                                 clk_i,
   input  logic                                 rst_n_i,
   input  logic                                 soft_rst_i,

   // write side
   input  logic                                 push_i,
   input  axis_out_pkg::fifo_word_u             push_data_i,
   output logic                                 full_o,

   // read side, first word falls through
   input  logic                                 pop_i,
   output axis_out_pkg::fifo_word_u             pop_data_o,
   output logic                                 empty_o,

   output logic [axis_out_pkg::LEVEL_W-1:0]     level_o
);

   axis_out_pkg::fifo_word_u mem [axis_out_pkg::FIFO_DEPTH];

   logic [axis_out_pkg::FIFO_ADDR_W-1:0] wr_ptr_q;
   logic [axis_out_pkg::FIFO_ADDR_W-1:0] rd_ptr_q;
   logic [axis_out_pkg::LEVEL_W-1:0]     level_q;

   logic full;
   logic empty;
   logic do_push;
   logic do_pop;

   // flags come straight from the occupancy count
   assign full = (level_q == axis_out_pkg::LEVEL_W'(axis_out_pkg::FIFO_DEPTH));
   assign empty = (level_q == '0);

   // a push into a full buffer is fine when a pop frees a slot at that edge
   assign do_pop = pop_i & ~empty;
   assign do_push = push_i & (~full | do_pop);

   // storage, written on push
   always_ff @(posedge clk_i) begin
      if (do_push) begin
         mem[wr_ptr_q] <= push_data_i;
      end
   end

   // pointers wrap naturally, depth is a power of two
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
      end else if (soft_rst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
      end else begin
         if (do_push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (do_pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
      end
   end

   // occupancy
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         level_q <= '0;
      end else if (soft_rst_i) begin
         level_q <= '0;
      end else if (do_push && !do_pop) begin
         level_q <= level_q + 1'b1;
      end else if (do_pop && !do_push) begin
         level_q <= level_q - 1'b1;
      end
   end

   assign pop_data_o = mem[rd_ptr_q];
   assign full_o = full;
   assign empty_o = empty;
   assign level_o = level_q;

endmodule

// ==== hw/axis_out_pkg.sv ====
package axis_out_pkg;

   // host word and stream beat widths
   localparam int DATA_W = 32;
   localparam int TDATA_W = 8;

   // beats carried by one host word
   localparam int LANES = DATA_W / TDATA_W;
   localparam int LANE_W = 2;

   // word buffer between host port and serializer
   localparam int FIFO_DEPTH = 8;
   localparam int FIFO_ADDR_W = 3;

   // level spans 0 to FIFO_DEPTH, one bit wider than the address
   localparam int LEVEL_W = 4;

   // frame length setting, counted in beats
   localparam int NWORDS_W = 16;

   // one buffer entry
   // the host side writes it whole, the serializer reads it lane by lane
   // lane 0 sits in the low byte and goes out first
   typedef union packed {
      logic [DATA_W-1:0] word;
      logic [LANES-1:0][TDATA_W-1:0] lanes;
   } fifo_word_u;

endpackage

// ==== hw/axis_out_top.sv ====
`timescale 1ns/1ps

module axis_out_top (
   input  logic                                 clk_i,
   input  logic                                 rst_n_i,

   // configuration
   input  logic                                 soft_rst_i,
   input  logic                                 enable_i,
   input  logic [axis_out_pkg::NWORDS_W-1:0]    nwords_i,
   input  logic [axis_out_pkg::LEVEL_W-1:0]     threshold_i,

   // host write port
   input  logic                                 wr_req_i,
   input  logic [axis_out_pkg::DATA_W-1:0]      wr_data_i,
   output logic                                 wr_ack_o,

   // stream output
   output logic                                 axis_tvalid_o,
   output logic [axis_out_pkg::TDATA_W-1:0]     axis_tdata_o,
   output logic                                 axis_tlast_o,
   input  logic                                 axis_tready_i,

   // status
   output logic                                 irq_o,
   output logic [axis_out_pkg::LEVEL_W-1:0]     level_o
);

   logic                             push;
   axis_out_pkg::fifo_word_u         push_data;
   logic                             full;
   logic                             pop;
   axis_out_pkg::fifo_word_u         pop_data;
   logic                             empty;
   logic [axis_out_pkg::LEVEL_W-1:0] level;

   host_write_port i_host_write_port (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .soft_rst_i (soft_rst_i),
      .enable_i   (enable_i),
      .wr_req_i   (wr_req_i),
      .wr_data_i  (wr_data_i),
      .wr_ack_o   (wr_ack_o),
      .full_i     (full),
      .push_o     (push),
      .push_data_o(push_data)
   );

   axis_out_fifo i_axis_out_fifo (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .soft_rst_i (soft_rst_i),
      .push_i     (push),
      .push_data_i(push_data),
      .full_o     (full),
      .pop_i      (pop),
      .pop_data_o (pop_data),
      .empty_o    (empty),
      .level_o    (level)
   );

   axis_serializer i_axis_serializer (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .soft_rst_i   (soft_rst_i),
      .enable_i     (enable_i),
      .nwords_i     (nwords_i),
      .pop_data_i   (pop_data),
      .empty_i      (empty),
      .pop_o        (pop),
      .axis_tvalid_o(axis_tvalid_o),
      .axis_tdata_o (axis_tdata_o),
      .axis_tlast_o (axis_tlast_o),
      .axis_tready_i(axis_tready_i)
   );

   // low-water interrupt, stays high while the buffer drains below threshold
   assign irq_o = (level <= threshold_i);
   assign level_o = level;

endmodule

// ==== hw/axis_serializer.sv ====
`timescale 1ns/1ps

module axis_serializer (
   input  logic                                 clk_i,
   input  logic                                 rst_n_i,
   input  logic                                 soft_rst_i,
   input  logic                                 enable_i,

   // frame length in beats, zero behaves as one
   input  logic [axis_out_pkg::NWORDS_W-1:0]    nwords_i,

   // word buffer read side
   input  axis_out_pkg::fifo_word_u             pop_data_i,
   input  logic                                 empty_i,
   output logic                                 pop_o,

   // stream output
   output logic                                 axis_tvalid_o,
   output logic [axis_out_pkg::TDATA_W-1:0]     axis_tdata_o,
   output logic                                 axis_tlast_o,
   input  logic                                 axis_tready_i
);

   // held word and its decode state
   axis_out_pkg::fifo_word_u word_q;
   logic                                 loaded_q;
   logic [axis_out_pkg::LANE_W-1:0]      lane_q;

   // beats already sent in the current frame
   logic [axis_out_pkg::NWORDS_W-1:0]    beat_cnt_q;

   logic [axis_out_pkg::NWORDS_W-1:0]    nwords_eff;
   logic [axis_out_pkg::NWORDS_W-1:0]    beat_cnt_inc;
   logic                                 tvalid;
   logic                                 xfer;
   logic                                 last_lane;
   logic                                 last_beat;
   logic                                 word_done;
   logic                                 pop;

   assign nwords_eff = (nwords_i == '0) ? axis_out_pkg::NWORDS_W'(1) : nwords_i;
   assign beat_cnt_inc = beat_cnt_q + 1'b1;

   // the beat on the wire is number beat_cnt_q + 1 of the frame
   assign last_beat = (beat_cnt_inc == nwords_eff);
   assign last_lane = (lane_q == axis_out_pkg::LANE_W'(axis_out_pkg::LANES - 1));

   // enable low hides the beat but keeps it held
   assign tvalid = loaded_q & enable_i;
   assign xfer = tvalid & axis_tready_i;

   // word is finished after its last lane or after the tlast beat
   // remaining lanes behind tlast are padding and simply dropped here
   assign word_done = xfer & (last_lane | last_beat);

   // refill when empty-handed, or back to back as the held word finishes
   assign pop = enable_i
              & ~empty_i
              & ~soft_rst_i
              & (~loaded_q | word_done);

   // payload register, loaded on every pop
   always_ff @(posedge clk_i) begin
      if (pop) begin
         word_q <= pop_data_i;
      end
   end

   // lane stepping and word ownership
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         loaded_q <= 1'b0;
         lane_q <= '0;
      end else if (soft_rst_i) begin
         loaded_q <= 1'b0;
         lane_q <= '0;
      end else if (pop) begin
         // fresh word always starts at lane 0
         loaded_q <= 1'b1;
         lane_q <= '0;
      end else if (word_done) begin
         // nothing waiting in the buffer
         loaded_q <= 1'b0;
         lane_q <= '0;
      end else if (xfer) begin
         lane_q <= lane_q + 1'b1;
      end
   end

   // frame beat counter, cleared by the tlast transfer
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         beat_cnt_q <= '0;
      end else if (soft_rst_i) begin
         beat_cnt_q <= '0;
      end else if (xfer) begin
         if (last_beat) begin
            beat_cnt_q <= '0;
         end else begin
            beat_cnt_q <= beat_cnt_inc;
         end
      end
   end

   assign pop_o = pop;

   assign axis_tvalid_o = tvalid;
   assign axis_tdata_o = word_q.lanes[lane_q];
   assign axis_tlast_o = tvalid & last_beat;

endmodule

// ==== hw/host_write_port.sv ====
`timescale 1ns/1ps

module host_write_port (
   input  logic                                 clk_i,
   input  logic                                 rst_n_i,
   input  logic                                 soft_rst_i,
   input  logic                                 enable_i,

   // four-phase host write port
   input  logic                                 wr_req_i,
   input  logic [axis_out_pkg::DATA_W-1:0]      wr_data_i,
   output logic                                 wr_ack_o,

   // push side of the word buffer
   input  logic                                 full_i,
   output logic                                 push_o,
   output axis_out_pkg::fifo_word_u             push_data_o
);

   // request tracker, low is idle and high is acknowledged
   logic ack_q;
   logic push;

   // a new request is taken only from idle
   // back-pressure comes from holding off the push, and with it the ack
   assign push = wr_req_i
               & ~ack_q
               & enable_i
               & ~full_i
               & ~soft_rst_i;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
      end else if (soft_rst_i) begin
         ack_q <= 1'b0;
      end else if (push) begin
         // ack rises at the edge that stores the word
         ack_q <= 1'b1;
      end else if (ack_q && !wr_req_i) begin
         // host has dropped its request, close the handshake
         ack_q <= 1'b0;
      end
   end

   assign wr_ack_o = ack_q;
   assign push_o = push;

   // host keeps data stable while req is high, no need to capture it
   assign push_data_o.word = wr_data_i;

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module tb_axis_out \
   --Mdir obj_dir -o sim_axis_out
status=$?
if [ $status -ne 0 ]; then
   echo "build failed with status $status"
   exit 1
fi

output=$(./obj_dir/sim_axis_out)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "No errors"; then
   exit 0
fi
exit 1

// ==== verif/axis_out_checker.sv ====
`timescale 1ns/1ps

module axis_out_checker (
   input  logic                                 clk_i,
   input  logic                                 rst_n_i,
   input  logic                                 soft_rst_i,
   input  logic                                 enable_i,
   input  logic [axis_out_pkg::NWORDS_W-1:0]    nwords_i,
   input  logic [axis_out_pkg::LEVEL_W-1:0]     threshold_i,
   input  logic                                 wr_ack_i,
   input  logic [axis_out_pkg::DATA_W-1:0]      wr_data_i,
   input  logic                                 tvalid_i,
   input  logic [axis_out_pkg::TDATA_W-1:0]     tdata_i,
   input  logic                                 tlast_i,
   input  logic                                 tready_i,
   input  logic                                 irq_i,
   input  logic [axis_out_pkg::LEVEL_W-1:0]     level_i
);

   string test_name = "reset";
   int    err_cnt = 0;
   int    frame_cnt = 0;

   // expected beats with lane 0 of each acknowledged word first
   logic [axis_out_pkg::TDATA_W-1:0] lanes_q [$];
   logic ack_prev = 1'b0;
   int   beat_cnt = 0;
   int   lane_idx = 0;

   // words waiting in the buffer and whether the serializer holds one
   int   exp_level = 0;
   logic held = 1'b0;

   task automatic report_value(input string what, input int exp, input int act);
      if (exp != act) begin
         $display("[ERROR] %s: %s expected %0h actual %0h", test_name, what, exp, act);
         err_cnt++;
      end
   endtask

   task automatic report_text(input string msg);
      $display("%s: %s", test_name, msg);
      err_cnt++;
   endtask

   always @(posedge clk_i) begin
      int nw_eff;
      logic exp_last;
      logic word_end;
      nw_eff = (nwords_i == '0) ? 1 : int'(nwords_i);
      word_end = 1'b0;
      if (!rst_n_i || soft_rst_i) begin
         lanes_q.delete();
         beat_cnt = 0;
         lane_idx = 0;
         ack_prev = 1'b0;
         exp_level = 0;
         held = 1'b0;
      end else begin
         // word is still on wr_data_i one edge after the ack rose
         // the buffer took it at the edge the ack rose on
         if (wr_ack_i && !ack_prev) begin
            exp_level++;
            for (int k = 0; k < axis_out_pkg::LANES; k++) begin
               lanes_q.push_back(wr_data_i[k*axis_out_pkg::TDATA_W +: axis_out_pkg::TDATA_W]);
            end
         end
         ack_prev = wr_ack_i;

         // low-water interrupt against the modelled level
         report_value("level_o", exp_level, int'(level_i));
         report_value("irq_o", (exp_level <= int'(threshold_i)) ? 1 : 0, int'(irq_i));

         if (tvalid_i && tready_i) begin
            if (lanes_q.size() == 0) begin
               report_text("a beat was transferred although no word was written");
            end else begin
               exp_last = (beat_cnt + 1 == nw_eff);
               word_end = exp_last || (lane_idx == axis_out_pkg::LANES - 1);
               report_value("tdata", int'(lanes_q[0]), int'(tdata_i));
               report_value("tlast", int'(exp_last), int'(tlast_i));
               void'(lanes_q.pop_front());
               if (exp_last) begin
                  // rest of the word is padding
                  for (int k = lane_idx + 1; k < axis_out_pkg::LANES; k++) begin
                     void'(lanes_q.pop_front());
                  end
                  lane_idx = 0;
                  beat_cnt = 0;
                  frame_cnt++;
               end else begin
                  lane_idx = (lane_idx + 1) % axis_out_pkg::LANES;
                  beat_cnt++;
               end
            end
         end

         // serializer fetches when it holds nothing or as its word ends
         if (enable_i && exp_level > 0 && (!held || word_end)) begin
            exp_level--;
            held = 1'b1;
         end else if (word_end) begin
            held = 1'b0;
         end
      end
   end

endmodule

// ==== verif/axis_out_properties.sv ====
`timescale 1ns/1ps

module axis_out_properties (
   input logic                                 clk_i,
   input logic                                 rst_n_i,
   input logic                                 soft_rst_i,
   input logic                                 enable_i,
   input logic                                 wr_req_i,
   input logic                                 wr_ack_o,
   input logic                                 pop_i,
   input logic [axis_out_pkg::LEVEL_W-1:0]     level_i,
   input logic                                 axis_tvalid_o,
   input logic [axis_out_pkg::TDATA_W-1:0]     axis_tdata_o,
   input logic                                 axis_tlast_o,
   input logic                                 axis_tready_i
);

   int fail_cnt = 0;

   // a stalled beat holds until taken, unless enable drops it
   property stall_holds_beat;
      @(posedge clk_i) disable iff (!rst_n_i || soft_rst_i)
         axis_tvalid_o && !axis_tready_i |=> !enable_i
            || (axis_tvalid_o && $stable(axis_tdata_o) && $stable(axis_tlast_o));
   endproperty

   property ack_needs_req;
      @(posedge clk_i) disable iff (!rst_n_i)
         $rose(wr_ack_o) |-> $past(wr_req_i);
   endproperty

   // every acknowledged word lands in the buffer
   // a push into a full buffer would leave the level unchanged
   property no_push_when_full;
      @(posedge clk_i) disable iff (!rst_n_i)
         $rose(wr_ack_o) |->
            level_i == ($past(pop_i) ? $past(level_i) : $past(level_i) + 1'b1);
   endproperty

   a_stall: assert property (stall_holds_beat)
      else begin
         $error("stream beat changed under a stall");
         fail_cnt++;
      end
   a_ack: assert property (ack_needs_req)
      else begin
         $error("wr_ack_o rose without a request");
         fail_cnt++;
      end
   a_full: assert property (no_push_when_full)
      else begin
         $error("acknowledged word was not stored in the buffer");
         fail_cnt++;
      end

endmodule

bind axis_out_top axis_out_properties i_properties (
   .clk_i        (clk_i),
   .rst_n_i      (rst_n_i),
   .soft_rst_i   (soft_rst_i),
   .enable_i     (enable_i),
   .wr_req_i     (wr_req_i),
   .wr_ack_o     (wr_ack_o),
   .pop_i        (pop),
   .level_i      (level),
   .axis_tvalid_o(axis_tvalid_o),
   .axis_tdata_o (axis_tdata_o),
   .axis_tlast_o (axis_tlast_o),
   .axis_tready_i(axis_tready_i)
);

// ==== verif/tb_axis_out.sv ====
`timescale 1ns/1ps

module tb_axis_out;

   localparam int NTESTS = 6;

   logic        clk_i = 1'b0;
   logic        rst_n_i;
   logic        soft_rst_i;
   logic        enable_i;
   logic [15:0] nwords_i;
   logic [3:0]  threshold_i;
   logic        wr_req_i;
   logic [31:0] wr_data_i;
   logic        wr_ack_o;
   logic        axis_tvalid_o;
   logic [7:0]  axis_tdata_o;
   logic        axis_tlast_o;
   logic        axis_tready_i = 1'b1;
   logic        irq_o;
   logic [3:0]  level_o;

   // frame table
   // tready modes 0 always high, 1 random, 2 held low, 3 disable and soft reset
   string names [NTESTS] = '{"byte_order", "padding", "after_padding",
                             "backpressure", "fifo_full", "enable_soft_rst"};
   int nwords_tab [NTESTS] = '{8, 6, 4, 8, 40, 8};
   int words_tab  [NTESTS] = '{2, 2, 1, 2, 10, 2};
   int mode_tab   [NTESTS] = '{0, 0, 0, 1, 2, 3};
   logic [31:0] base_tab [NTESTS] = '{32'h0302_0100, 32'h1312_1110, 32'h2322_2120,
                                      32'h3332_3130, 32'h4342_4140, 32'h8382_8180};

   int   tready_mode = 0;
   logic hold_tready = 1'b0;
   int   cycles = 0;
   int   limit = 200;

   always #4 clk_i = ~clk_i;

   axis_out_top i_dut (.*);

   axis_out_checker i_checker (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .soft_rst_i (soft_rst_i),
      .enable_i   (enable_i),
      .nwords_i   (nwords_i),
      .threshold_i(threshold_i),
      .wr_ack_i   (wr_ack_o),
      .wr_data_i  (wr_data_i),
      .tvalid_i   (axis_tvalid_o),
      .tdata_i    (axis_tdata_o),
      .tlast_i    (axis_tlast_o),
      .tready_i   (axis_tready_i),
      .irq_i      (irq_o),
      .level_i    (level_o)
   );

   // tready pattern per mode
   always @(posedge clk_i) begin
      logic [31:0] r;
      #1;
      r = $urandom();
      if (tready_mode == 1) begin
         axis_tready_i = r[0];
      end else begin
         axis_tready_i = !hold_tready;
      end
   end

   always @(posedge clk_i) begin
      cycles++;
      if (cycles >= limit) begin
         $display("timeout: the run did not finish within %0d cycles", limit);
         $display("Errors found");
         $finish;
      end
   end

   task automatic finish_handshake();
      while (!wr_ack_o) begin
         @(posedge clk_i);
         #1;
      end
      wr_req_i = 1'b0;
      while (wr_ack_o) begin
         @(posedge clk_i);
         #1;
      end
   endtask

   task automatic write_word(input logic [31:0] data);
      @(posedge clk_i);
      #1;
      wr_data_i = data;
      wr_req_i = 1'b1;
      finish_handshake();
   endtask

   task automatic write_word_when_full(input logic [31:0] data);
      @(posedge clk_i);
      #1;
      wr_data_i = data;
      wr_req_i = 1'b1;
      repeat (10) begin
         @(posedge clk_i);
         #1;
         if (wr_ack_o) begin
            i_checker.report_text("wr_ack_o rose while the buffer was full");
         end
      end
      // draining the serializer frees a slot for the waiting word
      hold_tready = 1'b0;
      finish_handshake();
   endtask

   task automatic disable_and_clear(input logic [31:0] data);
      // half a frame goes out and a second word stays held
      write_word(data);
      wait (i_checker.beat_cnt == 4);
      hold_tready = 1'b1;
      write_word(data + 32'h0404_0404);
      enable_i = 1'b0;
      wr_req_i = 1'b1;
      repeat (10) begin
         @(posedge clk_i);
         #1;
         if (wr_ack_o || axis_tvalid_o) begin
            i_checker.report_text("acknowledge or tvalid seen while disabled");
         end
      end
      wr_req_i = 1'b0;
      soft_rst_i = 1'b1;
      @(posedge clk_i);
      #1;
      soft_rst_i = 1'b0;
      i_checker.report_value("level_o after soft reset", 0, int'(level_o));
      enable_i = 1'b1;
      hold_tready = 1'b0;
   endtask

   initial begin
      int err_before;
      int passed;
      int total_err;
      void'($urandom(32'hcc5d_e69f));
      passed = 0;
      for (int t = 0; t < NTESTS; t++) begin
         limit += 32 * words_tab[t];
      end
      rst_n_i = 1'b0;
      soft_rst_i = 1'b0;
      enable_i = 1'b1;
      nwords_i = 16'd8;
      threshold_i = 4'd2;
      wr_req_i = 1'b0;
      wr_data_i = '0;
      repeat (3) @(posedge clk_i);
      #1;
      rst_n_i = 1'b1;

      for (int t = 0; t < NTESTS; t++) begin
         err_before = i_checker.err_cnt;
         i_checker.test_name = names[t];
         nwords_i = 16'(nwords_tab[t]);
         tready_mode = mode_tab[t];
         hold_tready = (mode_tab[t] == 2);
         if (mode_tab[t] == 3) begin
            disable_and_clear(32'hf3f2_f1f0);
         end
         for (int w = 0; w < words_tab[t]; w++) begin
            if (mode_tab[t] == 2 && w == words_tab[t] - 1) begin
               // one word in the serializer and eight in the buffer
               i_checker.report_value("level_o while stalled", 8, int'(level_o));
               write_word_when_full(base_tab[t] + 32'(w) * 32'h0404_0404);
            end else begin
               write_word(base_tab[t] + 32'(w) * 32'h0404_0404);
            end
         end
         wait (i_checker.frame_cnt == t + 1);
         if (i_checker.err_cnt == err_before) begin
            passed++;
            $display("test %s passed", names[t]);
         end else begin
            $display("test %s failed with %0d errors", names[t],
                     i_checker.err_cnt - err_before);
         end
      end

      repeat (4) @(posedge clk_i);
      total_err = i_checker.err_cnt + i_dut.i_properties.fail_cnt;
      $display("tests passed: %0d of %0d, errors: %0d", passed, NTESTS, total_err);
      if (total_err == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule
